// ==== compile.f ====
common/ma_pkg.sv
branch/branch_resolver.sv
branch/pc_unit.sv
rtl/ma_control.sv
rtl/wb_register.sv
rtl/ma_stage.sv
testbench/ma_checker.sv
testbench/tb_ma_stage.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_ma_stage
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_ma_stage.sv ====
// Testbench top of the MA stage that runs instruction streams through dut0 and reports the verdict
`timescale 1ns/1ns

module tb_ma_stage import ma_pkg::*; ();

    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_1000;
    localparam logic [31:0]     SEED      = 32'h7158051e;
    localparam int T_RESET       = 0;                   // Test ids
    localparam int T_ALU         = 1;
    localparam int T_BRANCH      = 2;
    localparam int T_JUMP        = 3;
    localparam int T_LOAD        = 4;
    localparam int T_STALL       = 5;
    localparam int NUM_TESTS     = 6;                   // Id after the last test
    localparam int STALL_TIMEOUT = 20;                  // Cycles allowed for stall release

    logic              clk_i;
    logic              arst_n_i;
    logic              lsu_ready_i;
    logic              stall_o;
    logic              flush_o;
    exma_item_t        exma_i;
    logic [XLEN-1:0]   lsu_data_i;
    logic [XLEN-1:0]   toc_addr_o;
    logic [XLEN-1:0]   pc_o;
    wb_item_t          wb_o;
    logic [2:0]        test_id;
    logic [31:0]       checks;                          // Compares counted by the checker
    logic [31:0]       errors;
    logic [31:0]       rng_state;
    logic              timed_out;

    always #20 clk_i = ~clk_i;                          // 40 ns period

    ma_stage #(.BOOT_ADDR(BOOT_ADDR)) dut0 (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .exma_i(exma_i), .lsu_data_i(lsu_data_i),
        .lsu_ready_i(lsu_ready_i), .stall_o(stall_o), .flush_o(flush_o),
        .toc_addr_o(toc_addr_o), .pc_o(pc_o), .wb_o(wb_o)
    );

    ma_checker #(.BOOT_ADDR(BOOT_ADDR), .NUM_TESTS(NUM_TESTS)) chk0 (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .exma_i(exma_i), .lsu_data_i(lsu_data_i),
        .lsu_ready_i(lsu_ready_i), .stall_i(stall_o), .flush_i(flush_o),
        .toc_addr_i(toc_addr_o), .pc_i(pc_o), .wb_i(wb_o), .test_id_i(test_id),
        .checks_o(checks), .errors_o(errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Random fields without control bits
    function automatic exma_item_t random_item();
        exma_item_t  ex;
        logic [31:0] r;
        r = rand32();
        ex = '0;
        ex.func = r[2:0];
        ex.rd = r[7:3];
        ex.ictrl.rvc = r[8];
        ex.val = rand32();
        ex.tgt = rand32() & ~32'h1;
        ex.pred_tadd = ex.tgt;
        return ex;
    endfunction

    function automatic logic [2:0] load_code(input int k);
        case (k)
            0:       return LD_B;
            1:       return LD_H;
            2:       return LD_W;
            3:       return LD_BU;
            default: return LD_HU;
        endcase
    endfunction

    task automatic step();
        @(posedge clk_i);
        #2;                                             // Drive point after the edge
    endtask

    task automatic issue(input exma_item_t ex, input logic [31:0] data);
        exma_i = ex;
        lsu_data_i = data;
        lsu_ready_i = 1'b1;
        step();
    endtask

    // Two bubbles drain the MA/WB register before the next test starts
    task automatic start_test(input int id);
        exma_i = '0;
        repeat (2) step();
        test_id = 3'(id);
    endtask

    // Load or store with the bus not ready for a number of cycles
    task automatic stalled(input exma_item_t ex, input logic [31:0] data, input int delay);
        int waited;
        exma_i = ex;
        lsu_data_i = rand32();                          // Garbage while waiting
        lsu_ready_i = 1'b0;
        repeat (delay) step();
        lsu_data_i = data;
        lsu_ready_i = 1'b1;
        #1;
        waited = 0;
        while (stall_o && waited < STALL_TIMEOUT) begin
            @(posedge clk_i);
            #3;
            waited++;
        end
        if (stall_o) begin
            $display("Timeout: stall_o stayed high %0d cycles after lsu_ready_i rose", waited);
            timed_out = 1'b1;
        end
        step();                                         // Commit edge
    endtask

    initial begin : stimulus
        exma_item_t  ex;
        logic [31:0] r;
        int          i;
        int          k;
        clk_i = 1'b0;
        arst_n_i = 1'b0;
        exma_i = '0;
        lsu_data_i = '0;
        lsu_ready_i = 1'b0;
        test_id = 3'(T_RESET);
        rng_state = SEED;
        timed_out = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        lsu_ready_i = 1'b1;
        repeat (3) step();                              // Empty slot with pc at the boot address
        start_test(T_ALU);
        for (i = 0; i < 24; i++) begin
            ex = random_item();
            ex.ictrl.reg_dest = 1'b1;
            issue(ex, rand32());
        end
        start_test(T_BRANCH);
        for (i = 0; i < 16; i++) begin
            ex = random_item();
            r = rand32();
            ex.ictrl.bru = 1'b1;
            ex.func[0] = BR_COND;
            case (i)
                0: {ex.val[0], ex.predicted} = 2'b10;   // Taken but predicted not taken
                1: {ex.val[0], ex.predicted} = 2'b01;   // Not taken but predicted taken
                2: {ex.val[0], ex.predicted} = 2'b11;   // Correct taken
                3: begin
                    {ex.val[0], ex.predicted} = 2'b11;
                    ex.pred_tadd = ex.tgt + 32'd8;      // Wrong predicted target
                end
                default: begin
                    {ex.val[0], ex.predicted} = r[1:0];
                    ex.pred_tadd = r[2] ? ex.tgt : ex.tgt ^ 32'h40;
                end
            endcase
            issue(ex, rand32());
        end
        start_test(T_JUMP);
        for (i = 0; i < 10; i++) begin
            ex = random_item();
            r = rand32();
            ex.ictrl.bru = 1'b1;
            ex.ictrl.reg_dest = 1'b1;
            ex.func[0] = BR_JUMP;
            ex.predicted = r[0];
            ex.pred_tadd = r[1] ? ex.tgt : ex.tgt + 32'd4;
            issue(ex, rand32());
        end
        start_test(T_LOAD);
        for (k = 0; k < 5; k++) begin
            for (i = 0; i < 4; i++) begin
                ex = random_item();
                ex.ictrl.lsu = 1'b1;
                ex.ictrl.reg_dest = 1'b1;
                ex.func = load_code(k);
                ex.val[1:0] = 2'(i);                    // Every byte offset
                issue(ex, rand32());
            end
        end
        start_test(T_STALL);
        for (i = 0; i < 8; i++) begin
            ex = random_item();
            r = rand32();
            ex.ictrl.lsu = 1'b1;
            ex.ictrl.reg_dest = (i % 4) != 3;           // Every fourth one is a store
            ex.func = load_code(int'(r % 5));
            stalled(ex, rand32(), 1 + int'((r >> 8) % 5));
        end
        start_test(NUM_TESTS);
        step();                                         // Checker closes the last test
        if (timed_out || errors != 0 || checks == 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    end

endmodule

// ==== testbench/ma_checker.sv ====
// Watches the MA stage ports, predicts every output with a reference model and counts mismatches
`timescale 1ns/1ns

module ma_checker import ma_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0,          // Reset pc of the DUT
    parameter int              NUM_TESTS = 6            // Test id that marks the end of the run
) (
    input  logic              clk_i,                    // Clock
    input  logic              arst_n_i,                 // Asynchronous reset, active low
    input  exma_item_t        exma_i,                   // Instruction driven into MA
    input  logic [XLEN-1:0]   lsu_data_i,               // Read data driven into MA
    input  logic              lsu_ready_i,              // LSU ready driven into MA
    input  logic              stall_i,                  // DUT stall
    input  logic              flush_i,                  // DUT flush
    input  logic [XLEN-1:0]   toc_addr_i,               // DUT redirect address
    input  logic [XLEN-1:0]   pc_i,                     // DUT pc
    input  wb_item_t          wb_i,                     // DUT write-back port
    input  logic [2:0]        test_id_i,                // Running test
    output logic [31:0]       checks_o,                 // Compares done so far
    output logic [31:0]       errors_o                  // Mismatches so far
);

    // Everything the model predicts for one cycle
    typedef struct packed {
        logic              stall;
        logic              flush;
        logic              commit;
        logic [XLEN-1:0]   toc;
        logic [XLEN-1:0]   pc_next;                     // Model pc after the next edge
        wb_item_t          wb;                          // Write-back seen after the next edge
    } expect_t;

    int              cur_test     = 0;
    int              test_checks  = 0;
    int              test_errors  = 0;
    int              total_checks = 0;
    int              total_errors = 0;
    logic [XLEN-1:0] model_pc;                          // Pc of the instruction in MA
    wb_item_t        pend_wb;                           // Expected wb_o in this cycle
    expect_t         exp;

    assign checks_o = total_checks;
    assign errors_o = total_errors;

    function automatic string test_name(input int id);
        case (id)
            0:       return "reset";
            1:       return "alu";
            2:       return "branch";
            3:       return "jump";
            4:       return "load";
            5:       return "stall";
            default: return "end";
        endcase
    endfunction

    // Expected stage behavior derived from the handshake, branch and load rules
    function automatic expect_t predict_outputs(input exma_item_t ex,
                                                input logic [XLEN-1:0] data,
                                                input logic ready,
                                                input logic [XLEN-1:0] pc);
        expect_t          e;
        logic             empty;
        logic             taken;
        logic [XLEN-1:0]  seq;
        logic [XLEN-1:0]  word;
        logic [XLEN-1:0]  ld;
        empty    = !(ex.ictrl.lsu || ex.ictrl.bru || ex.ictrl.rvc || ex.ictrl.reg_dest);
        e.stall  = ex.ictrl.lsu && !ready;              // Bus transfer still open
        e.commit = !empty && !e.stall;
        seq      = pc + (ex.ictrl.rvc ? 32'd2 : 32'd4);
        taken    = ex.ictrl.bru && (ex.func[0] || ex.val[0]);  // Jump or true condition
        e.flush  = e.commit && ex.ictrl.bru &&
                   ((taken != ex.predicted) || (taken && (ex.tgt != ex.pred_tadd)));
        e.toc     = taken ? ex.tgt : seq;
        e.pc_next = e.commit ? e.toc : pc;              // Pc holds on stall or bubble
        word = data >> (8 * int'(ex.val[1:0]));         // Addressed byte to bit 0
        case (ex.func)
            3'b000:  ld = {{24{word[7]}}, word[7:0]};
            3'b001:  ld = {{16{word[15]}}, word[15:0]};
            3'b100:  ld = {24'b0, word[7:0]};
            3'b101:  ld = {16'b0, word[15:0]};
            default: ld = word;                         // Word load
        endcase
        e.wb.we = e.commit && ex.ictrl.reg_dest;
        e.wb.rd = ex.rd;
        if (ex.ictrl.lsu) begin
            e.wb.val = ld;
        end else if (ex.ictrl.bru) begin
            e.wb.val = seq;                             // Link address
        end else begin
            e.wb.val = ex.val;
        end
        return e;
    endfunction

    task automatic compare_value(input string what, input logic [XLEN-1:0] expected,
                                 input logic [XLEN-1:0] actual);
        test_checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("Fail %s: %s expected %h actual %h", test_name(cur_test), what,
                     expected, actual);
        end
    endtask

    // Per-test line and running totals
    task automatic close_test();
        total_checks += test_checks;
        total_errors += test_errors;
        $display("Test %s finished: %0d checks, %0d errors", test_name(cur_test),
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // Outputs are settled at the falling edge and inputs were driven after the rising one
    always @(negedge clk_i) begin : compare
        if (!arst_n_i) begin
            model_pc = BOOT_ADDR;
            pend_wb  = '0;
        end else begin
            if (int'(test_id_i) != cur_test) begin
                close_test();
                cur_test = int'(test_id_i);
                if (cur_test == NUM_TESTS) begin
                    $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
                end
            end
            exp = predict_outputs(exma_i, lsu_data_i, lsu_ready_i, model_pc);
            if (cur_test < NUM_TESTS) begin             // Nothing left to count after the totals
                compare_value("pc_o", model_pc, pc_i);
                compare_value("wb_o.we", 32'(pend_wb.we), 32'(wb_i.we));
                if (pend_wb.we) begin
                    compare_value("wb_o.rd", 32'(pend_wb.rd), 32'(wb_i.rd));
                    compare_value("wb_o.val", pend_wb.val, wb_i.val);
                end
                compare_value("stall_o", 32'(exp.stall), 32'(stall_i));
                compare_value("flush_o", 32'(exp.flush), 32'(flush_i));
                if (exp.commit || exp.stall) begin
                    compare_value("toc_addr_o", exp.toc, toc_addr_i);  // Only for a live slot
                end
            end
            model_pc = exp.pc_next;
            pend_wb  = exp.wb;
        end
    end

endmodule

// ==== rtl/ma_stage.sv ====
// Memory-access stage top, joins stage control, branch resolution, pc and the MA/WB register
`timescale 1ns/1ns

module ma_stage import ma_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0           // Reset value of the program counter
) (
    input  logic              clk_i,                    // Clock
    input  logic              arst_n_i,                 // Asynchronous reset, active low

    input  exma_item_t        exma_i,                   // Instruction from execute stage
    input  logic [XLEN-1:0]   lsu_data_i,               // LSU read data
    input  logic              lsu_ready_i,              // LSU transfer done

    output logic              stall_o,                  // Stall for older stages
    output logic              flush_o,                  // Flush for older stages
    output logic [XLEN-1:0]   toc_addr_o,               // Transfer-of-control address
    output logic [XLEN-1:0]   pc_o,                     // Program counter
    output wb_item_t          wb_o                      // Write-back result
);

    logic              commit;                          // Instruction leaves MA this cycle
    logic              taken;                           // Branch or jump taken
    logic [XLEN-1:0]   next_pc;                         // Sequential address
    logic [XLEN-1:0]   wb_val;                          // Selected stage result

    // Empty, stall, commit and result selection
    ma_control m_control (
        .exma_i      (exma_i),
        .lsu_ready_i (lsu_ready_i),
        .lsu_data_i  (lsu_data_i),
        .next_pc_i   (next_pc),
        .commit_o    (commit),
        .stall_o     (stall_o),
        .wb_val_o    (wb_val)
    );

    // Outcome against prediction
    branch_resolver m_branch (
        .exma_i   (exma_i),
        .commit_i (commit),
        .taken_o  (taken),
        .flush_o  (flush_o)
    );

    // Program counter and redirect address
    pc_unit #(
        .BOOT_ADDR (BOOT_ADDR)
    ) m_pc (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .exma_i     (exma_i),
        .commit_i   (commit),
        .taken_i    (taken),
        .pc_o       (pc_o),
        .next_pc_o  (next_pc),
        .toc_addr_o (toc_addr_o)
    );

    // MA/WB register with load decoding
    wb_register m_wb (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .exma_i   (exma_i),
        .commit_i (commit),
        .wb_val_i (wb_val),
        .wb_o     (wb_o)
    );

endmodule

// ==== rtl/wb_register.sv ====
// MA/WB pipeline register with the load decoder that shapes the write-back result
`timescale 1ns/1ns

module wb_register import ma_pkg::*; (
    input  logic              clk_i,                    // Clock
    input  logic              arst_n_i,                 // Asynchronous reset, active low

    input  exma_item_t        exma_i,                   // Instruction in MA
    input  logic              commit_i,                 // Instruction leaves MA
    input  logic [XLEN-1:0]   wb_val_i,                 // Selected stage result

    output wb_item_t          wb_o                      // Write-back result
);

    ictrl_t            ictrl_q;                         // Control of the WB slot
    rf_add_t           rd_q;                            // Destination register
    logic [XLEN-1:0]   val_q;                           // Result or raw load word
    ld_info_t          ldi_q;                           // Load width and offset
    ld_info_t          ldi_d;
    logic [XLEN-1:0]   ld_shift;                        // Addressed bytes moved to bit 0
    logic [XLEN-1:0]   ld_data;                         // Extended load value

    // Load function with the low address bits
    assign ldi_d.func   = ld_func_e'(exma_i.func);
    assign ldi_d.offset = exma_i.val[1:0];

    // Bubble enters whenever nothing commits
    always_ff @(posedge clk_i or negedge arst_n_i) begin : ctrl_reg
        if (!arst_n_i) begin
            ictrl_q <= '0;
        end else begin
            ictrl_q <= commit_i ? exma_i.ictrl : '0;
        end
    end

    // Payload follows the committed instruction
    always_ff @(posedge clk_i) begin : data_reg
        if (commit_i) begin
            rd_q  <= exma_i.rd;
            val_q <= wb_val_i;
            ldi_q <= ldi_d;
        end
    end

    // Align the addressed byte or halfword
    assign ld_shift = val_q >> {ldi_q.offset, 3'b000};

    // Sign or zero extension by load function
    always_comb begin : load_decoder
        case (ldi_q.func)
            LD_B: begin
                ld_data = {{(XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
            end
            LD_H: begin
                ld_data = {{(XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
            end
            LD_BU: begin
                ld_data = {{(XLEN-8){1'b0}}, ld_shift[7:0]};
            end
            LD_HU: begin
                ld_data = {{(XLEN-16){1'b0}}, ld_shift[15:0]};
            end
            default: begin
                ld_data = ld_shift;                     // Full word
            end
        endcase
    end

    // Register file write only for instructions with a destination
    assign wb_o.we  = ictrl_q.reg_dest;
    assign wb_o.rd  = rd_q;
    assign wb_o.val = ictrl_q.lsu ? ld_data : val_q;    // Loads go through the decoder

endmodule

// ==== rtl/ma_control.sv ====
// Stage control of MA, derives stall and commit and picks the value stored for write-back
`timescale 1ns/1ns

module ma_control import ma_pkg::*; (
    input  exma_item_t        exma_i,                   // Instruction in MA
    input  logic              lsu_ready_i,              // Data-bus transfer finished
    input  logic [XLEN-1:0]   lsu_data_i,               // Raw read data
    input  logic [XLEN-1:0]   next_pc_i,                // Link address

    output logic              commit_o,                 // Instruction leaves MA
    output logic              stall_o,                  // Hold the older stages
    output logic [XLEN-1:0]   wb_val_o                  // Value for the MA/WB register
);

    logic empty;                                        // No instruction in the slot
    logic lsu_wait;                                     // Transfer still open

    // All control bits clear means a bubble
    assign empty    = (exma_i.ictrl == '0);

    // Only load and store wait on the bus
    assign lsu_wait = exma_i.ictrl.lsu & ~lsu_ready_i;

    assign stall_o  = lsu_wait;

    // Nothing cancels an instruction here, so it goes as soon as it is not waiting
    assign commit_o = ~empty & ~lsu_wait;

    // Result selection
    always_comb begin : result_select
        if (exma_i.ictrl.lsu) begin
            wb_val_o = lsu_data_i;                      // Decoded later in WB
        end else if (exma_i.ictrl.bru) begin
            wb_val_o = next_pc_i;                       // Return address of a jump
        end else begin
            wb_val_o = exma_i.val;                      // ALU result
        end
    end

endmodule

// ==== branch/pc_unit.sv ====
// Program counter of the instruction in MA, its sequential successor and the redirect address
`timescale 1ns/1ns

module pc_unit import ma_pkg::*; #(
    parameter logic [XLEN-1:0] BOOT_ADDR = '0           // First fetch address
) (
    input  logic              clk_i,                    // Clock
    input  logic              arst_n_i,                 // Asynchronous reset, active low

    input  exma_item_t        exma_i,                   // Instruction in MA
    input  logic              commit_i,                 // Instruction leaves MA
    input  logic              taken_i,                  // Branch or jump taken

    output logic [XLEN-1:0]   pc_o,                     // Current program counter
    output logic [XLEN-1:0]   next_pc_o,                // Sequential address
    output logic [XLEN-1:0]   toc_addr_o                // Address for a redirect
);

    logic [XLEN-1:0] pc_q;                              // PC register
    logic [XLEN-1:0] pc_incr;                           // 2 or 4
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] new_pc;                            // Value loaded on commit

    // Instruction size
    assign pc_incr = exma_i.ictrl.rvc ? PC_INC_RVC : PC_INC_STD;

    assign next_pc = pc_q + pc_incr;

    // Jump target or fall-through
    assign new_pc  = taken_i ? exma_i.tgt : next_pc;

    // PC advances only with a committing instruction
    always_ff @(posedge clk_i or negedge arst_n_i) begin : pc_reg
        if (!arst_n_i) begin
            pc_q <= BOOT_ADDR;
        end else if (commit_i) begin
            pc_q <= new_pc;
        end
    end

    // Same selection serves the flush target
    assign toc_addr_o = new_pc;

    assign next_pc_o  = next_pc;
    assign pc_o       = pc_q;

endmodule

// ==== branch/branch_resolver.sv ====
// Resolves branches and jumps in MA and raises a flush when the fetch prediction was wrong
`timescale 1ns/1ns

module branch_resolver import ma_pkg::*; (
    input  exma_item_t        exma_i,                   // Instruction in MA
    input  logic              commit_i,                 // Instruction leaves MA

    output logic              taken_o,                  // Control transfer happens
    output logic              flush_o                   // Redirect the front end
);

    br_kind_e   kind;                                   // Branch or jump
    logic       active;                                 // Branch unit instruction
    logic       cond_true;                              // Condition from execute
    logic       taken;
    logic       dir_miss;                               // Direction differs from prediction
    logic       tgt_miss;                               // Target differs from prediction
    logic       mispredict;

    assign active    = exma_i.ictrl.bru;
    assign kind      = br_kind_e'(exma_i.func[0]);
    assign cond_true = exma_i.val[0];                   // Comparison result of EX

    // Jumps always go, branches only on a true condition
    always_comb begin : outcome
        taken = 1'b0;
        if (active) begin
            case (kind)
                BR_JUMP: taken = 1'b1;
                BR_COND: taken = cond_true;
                default: taken = 1'b0;
            endcase
        end
    end

    // Wrong direction in either sense
    assign dir_miss   = taken != exma_i.predicted;

    // Right direction but fetch went to another address
    assign tgt_miss   = taken & (exma_i.tgt != exma_i.pred_tadd);

    assign mispredict = active & (dir_miss | tgt_miss);

    assign taken_o    = taken;

    // Only a committing instruction may redirect
    assign flush_o    = commit_i & mispredict;

endmodule

// ==== common/ma_pkg.sv ====
// Shared types and constants of the memory-access stage, imported by every stage module
package ma_pkg;

    // Data and address width
    localparam int XLEN     = 32;
    // Register file address width
    localparam int RF_ADD_W = 5;

    // Sequential increments of the program counter
    localparam logic [XLEN-1:0] PC_INC_RVC = 32'd2;     // Compressed instruction
    localparam logic [XLEN-1:0] PC_INC_STD = 32'd4;     // Full-width instruction

    typedef logic [RF_ADD_W-1:0] rf_add_t;              // Destination register address

    // Instruction control indicator, all zeros marks an empty slot
    typedef struct packed {
        logic lsu;                                      // Load or store
        logic bru;                                      // Branch or jump
        logic rvc;                                      // Compressed encoding
        logic reg_dest;                                 // Writes the register file
    } ictrl_t;

    // Load function, same values as the RISC-V funct3 field
    typedef enum logic [2:0] {
        LD_B  = 3'b000,                                 // Signed byte
        LD_H  = 3'b001,                                 // Signed halfword
        LD_W  = 3'b010,                                 // Word
        LD_BU = 3'b100,                                 // Unsigned byte
        LD_HU = 3'b101                                  // Unsigned halfword
    } ld_func_e;

    // Branch unit operation, carried in bit 0 of func
    typedef enum logic {
        BR_COND = 1'b0,                                 // Conditional branch
        BR_JUMP = 1'b1                                  // Unconditional jump
    } br_kind_e;

    // Instruction leaving the execute stage
    typedef struct packed {
        ictrl_t            ictrl;                       // Control indicator
        logic [2:0]        func;                        // Load code or branch kind
        rf_add_t           rd;                          // Destination register
        logic [XLEN-1:0]   val;                         // ALU result, LSU address or condition
        logic [XLEN-1:0]   tgt;                         // Computed branch target
        logic              predicted;                   // Predicted taken in fetch
        logic [XLEN-1:0]   pred_tadd;                   // Predicted target
    } exma_item_t;

    // Load information kept until write-back
    typedef struct packed {
        ld_func_e          func;                        // Width and extension
        logic [1:0]        offset;                      // Byte offset in the word
    } ld_info_t;

    // Write-back port towards the register file
    typedef struct packed {
        logic              we;                          // Write enable
        rf_add_t           rd;                          // Destination register
        logic [XLEN-1:0]   val;                         // Value to write
    } wb_item_t;

endpackage
